// ==== dv/bitcore_tb.sv ====
`include "bitcore_settings.svh"

module bitcore_tb;

   localparam int N_BODY = 40;
   localparam int N_TAIL = 8;
   localparam int N_PROG = 7 + N_BODY + N_TAIL + 1;
   localparam int GAP    = 65;

   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_OR   = 3;
   localparam int K_XOR  = 4;
   localparam int K_ADDI = 5;
   localparam int K_ANDI = 6;
   localparam int K_ORI  = 7;
   localparam int K_XORI = 8;
   localparam int K_LUI  = 9;
   localparam int K_LW   = 10;
   localparam int K_SW   = 11;
   localparam int K_BEQ  = 12;
   localparam int K_BNE  = 13;
   localparam int K_JAL  = 14;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] i_dbus_rdt;
   logic        i_dbus_ack;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_we;
   logic        o_dbus_cyc;

   logic [31:0] imem [0:N_PROG-1];
   logic [31:0] dmem [0:63];
   int          prog_kind [0:N_PROG-1];
   int          prog_rd [0:N_PROG-1];
   int          prog_rs1 [0:N_PROG-1];
   int          prog_rs2 [0:N_PROG-1];
   logic [31:0] prog_imm [0:N_PROG-1];
   logic [31:0] xreg [0:7];
   logic [31:0] m_pc;
   integer      seed;
   int          errors;
   int          n_fetch;
   int          n_store;
   int          n_load;

   bitcore_top u_bitcore_top (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Twice 200 cycles for every program word
   initial begin
      #(200 * N_PROG * 2 * 10);
      $display("Timeout: the core stopped fetching or finishing bus cycles");
      $display("Run done: %0d fetches, %0d stores, %0d loads checked, %0d errors",
               n_fetch, n_store, n_load, errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic rand_below(input int n, output int v);
      v = $unsigned($random(seed)) % n;
   endtask

   // Standard RV32I encodings
   function automatic logic [31:0] encode_instr(input int k, input logic [4:0] d,
                                                input logic [4:0] s1, input logic [4:0] s2,
                                                input logic [31:0] im);
      case (k)
         K_ADD:   return {7'h00, s2, s1, 3'b000, d, 7'b0110011};
         K_SUB:   return {7'h20, s2, s1, 3'b000, d, 7'b0110011};
         K_AND:   return {7'h00, s2, s1, 3'b111, d, 7'b0110011};
         K_OR:    return {7'h00, s2, s1, 3'b110, d, 7'b0110011};
         K_XOR:   return {7'h00, s2, s1, 3'b100, d, 7'b0110011};
         K_ADDI:  return {im[11:0], s1, 3'b000, d, 7'b0010011};
         K_ANDI:  return {im[11:0], s1, 3'b111, d, 7'b0010011};
         K_ORI:   return {im[11:0], s1, 3'b110, d, 7'b0010011};
         K_XORI:  return {im[11:0], s1, 3'b100, d, 7'b0010011};
         K_LUI:   return {im[31:12], d, 7'b0110111};
         K_LW:    return {im[11:0], s1, 3'b010, d, 7'b0000011};
         K_SW:    return {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
         K_BEQ:   return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
         K_BNE:   return {im[12], im[10:5], s2, s1, 3'b001, im[4:1], im[11], 7'b1100011};
         default: return {im[20], im[10:1], im[11], im[19:12], d, 7'b1101111};
      endcase
   endfunction

   task automatic place_instr(input int idx, input int k, input int d, input int s1,
                              input int s2, input logic [31:0] im);
      prog_kind[idx] = k;
      prog_rd[idx]   = d;
      prog_rs1[idx]  = s1;
      prog_rs2[idx]  = s2;
      prog_imm[idx]  = im;
      imem[idx]      = encode_instr(k, 5'(d), 5'(s1), 5'(s2), im);
   endtask

   task automatic build_program();
      int          i;
      int          c;
      int          d;
      int          s1;
      int          s2;
      int          v;
      logic [31:0] im;
      // Known start values in x1 to x7
      for (i = 0; i < 7; i++) begin
         rand_below(4096, v);
         place_instr(i, K_ADDI, i + 1, 0, 0, 32'(v) - 32'd2048);
      end
      for (i = 7; i < 7 + N_BODY; i++) begin
         rand_below(15, c);
         rand_below(8, d);
         rand_below(8, s1);
         rand_below(8, s2);
         rand_below(4096, v);
         im = 32'(v) - 32'd2048;
         if (c == K_LUI) begin
            rand_below(1 << 20, v);
            im = {v[19:0], 12'h000};
         end else if (c == K_LW || c == K_SW) begin
            rand_below(64, v);
            s1 = 0;
            im = 32'(v * 4);
         end else if (c >= K_BEQ) begin
            // Short forward offsets that stay inside the store tail
            rand_below(4, v);
            im = 32'((v + 1) * 4);
            rand_below(2, v);
            if (v == 1) s2 = s1;
         end
         place_instr(i, c, d, s1, s2, im);
      end
      for (i = 0; i < N_TAIL; i++) begin
         place_instr(7 + N_BODY + i, K_SW, 0, 0, i, 32'(4 * (56 + i)));
      end
      place_instr(N_PROG - 1, K_JAL, 0, 0, 0, 32'd0);
   endtask

   // Instruction-level model of one step
   task automatic run_reference(input int idx, output logic is_mem,
                                output logic [31:0] mem_adr, output logic [31:0] mem_dat);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] im;
      logic [31:0] res;
      logic [31:0] nxt;
      logic        wr;
      a       = xreg[prog_rs1[idx]];
      b       = xreg[prog_rs2[idx]];
      im      = prog_imm[idx];
      nxt     = m_pc + 32'd4;
      wr      = 1'b1;
      res     = '0;
      is_mem  = 1'b0;
      mem_adr = a + im;
      mem_dat = b;
      case (prog_kind[idx])
         K_ADD:  res = a + b;
         K_SUB:  res = a - b;
         K_AND:  res = a & b;
         K_OR:   res = a | b;
         K_XOR:  res = a ^ b;
         K_ADDI: res = a + im;
         K_ANDI: res = a & im;
         K_ORI:  res = a | im;
         K_XORI: res = a ^ im;
         K_LUI:  res = im;
         K_LW: begin
            res    = dmem[mem_adr[7:2]];
            is_mem = 1'b1;
         end
         K_SW: begin
            wr                  = 1'b0;
            is_mem              = 1'b1;
            dmem[mem_adr[7:2]] = b;
         end
         K_BEQ: begin
            wr = 1'b0;
            if (a == b) nxt = m_pc + im;
         end
         K_BNE: begin
            wr = 1'b0;
            if (a != b) nxt = m_pc + im;
         end
         default: begin
            res = m_pc + 32'd4;
            nxt = m_pc + im;
         end
      endcase
      if (wr && prog_rd[idx] != 0) xreg[prog_rd[idx]] = res;
      m_pc = nxt;
   endtask

   task automatic check_fetch(input logic [31:0] got, input logic [31:0] exp);
      n_fetch++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch o_ibus_adr: got 0x%08h expected 0x%08h", got, exp);
      end
   endtask

   task automatic check_store(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [31:0] exp_adr, input logic [31:0] exp_dat);
      n_store++;
      if (we !== 1'b1) begin
         errors++;
         $display("Mismatch o_dbus_we: got 0x%0h expected 0x1", we);
      end
      if (adr !== exp_adr) begin
         errors++;
         $display("Mismatch o_dbus_adr: got 0x%08h expected 0x%08h", adr, exp_adr);
      end
      if (dat !== exp_dat) begin
         errors++;
         $display("Mismatch o_dbus_dat: got 0x%08h expected 0x%08h", dat, exp_dat);
      end
   endtask

   task automatic check_load_addr(input logic we, input logic [31:0] adr,
                                  input logic [31:0] exp_adr);
      n_load++;
      if (we !== 1'b0) begin
         errors++;
         $display("Mismatch o_dbus_we: got 0x%0h expected 0x0", we);
      end
      if (adr !== exp_adr) begin
         errors++;
         $display("Mismatch o_dbus_adr: got 0x%08h expected 0x%08h", adr, exp_adr);
      end
   endtask

   task automatic check_gap(input int got);
      if (got != GAP) begin
         errors++;
         $display("Mismatch o_ibus_cyc rise delay: got 0x%0h expected 0x%0h", got, GAP);
      end
   endtask

   task automatic serve_dbus(input logic is_store, input logic [31:0] exp_adr,
                             input logic [31:0] exp_dat);
      int d;
      while (!o_dbus_cyc) @(negedge clk);
      if (is_store) check_store(o_dbus_we, o_dbus_adr, o_dbus_dat, exp_adr, exp_dat);
      else check_load_addr(o_dbus_we, o_dbus_adr, exp_adr);
      rand_below(4, d);
      repeat (d) @(negedge clk);
      i_dbus_rdt = dmem[o_dbus_adr[7:2]];
      i_dbus_ack = 1'b1;
      @(negedge clk);
      i_dbus_ack = 1'b0;
   endtask

   initial begin
      int          a;
      int          idx;
      int          prev;
      int          d;
      int          gap;
      logic        is_mem;
      logic        dbus_seen;
      logic [31:0] exp_adr;
      logic [31:0] exp_dat;
      seed       = 72;
      errors     = 0;
      n_fetch    = 0;
      n_store    = 0;
      n_load     = 0;
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      for (a = 0; a < 64; a++) dmem[a] = 32'h6b00_0000 + 32'(a) * 32'h0102_0409;
      for (a = 0; a < 8; a++) xreg[a] = '0;
      m_pc = `BITCORE_RESET_PC;
      prev = -1;
      build_program();
      repeat (2) @(negedge clk);
      i_rst_n = 1'b1;
      while (1) begin
         while (!o_ibus_cyc) @(negedge clk);
         check_fetch(o_ibus_adr, m_pc);
         if (o_ibus_adr !== m_pc) break;
         idx = int'((m_pc - `BITCORE_RESET_PC) >> 2);
         // Second fetch of the closing self-jump
         if (idx == N_PROG - 1 && prev == N_PROG - 1) break;
         prev = idx;
         rand_below(4, d);
         repeat (d) @(negedge clk);
         i_ibus_rdt = imem[idx];
         i_ibus_ack = 1'b1;
         run_reference(idx, is_mem, exp_adr, exp_dat);
         @(negedge clk);
         i_ibus_ack = 1'b0;
         if (is_mem) begin
            serve_dbus(prog_kind[idx] == K_SW, exp_adr, exp_dat);
         end else begin
            gap       = 1;
            dbus_seen = 1'b0;
            while (!o_ibus_cyc) begin
               if (o_dbus_cyc) dbus_seen = 1'b1;
               @(negedge clk);
               gap++;
            end
            check_gap(gap);
            if (dbus_seen) begin
               errors++;
               $display("Data bus cycle started for a non-memory instruction at 0x%08h",
                        imem[idx]);
            end
         end
      end
      $display("Run done: %0d fetches, %0d stores, %0d loads checked, %0d errors",
               n_fetch, n_store, n_load, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/bitcore_pkg.sv
verilog/bitcore_control.sv
verilog/bitcore_immdec.sv
verilog/bitcore_alu.sv
verilog/bitcore_regfile.sv
verilog/bitcore_pc.sv
verilog/bitcore_lsu.sv
verilog/bitcore_top.sv
dv/bitcore_tb.sv

// ==== verilog/bitcore_alu.sv ====
module bitcore_alu (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  bitcore_pkg::step_t     i_step,
   input  bitcore_pkg::alu_ctrl_t i_alu,
   input  bitcore_pkg::serial_t   i_bits,
   output logic                   o_rd_bit,
   output logic                   o_eq
);

   logic op_b;
   logic b_eff;
   logic cin;
   logic carry;
   logic sum;
   logic mismatch;

   assign op_b  = i_alu.use_imm ? i_bits.imm : i_bits.rs2;
   // Subtract is add of the inverted operand plus one
   assign b_eff = op_b ^ i_alu.sub;
   assign cin   = i_step.first ? i_alu.sub : carry;
   assign sum   = i_bits.rs1 ^ b_eff ^ cin;

   always_comb begin
      case (i_alu.bool_op)
         2'd1:    o_rd_bit = i_bits.rs1 & op_b;
         2'd2:    o_rd_bit = i_bits.rs1 | op_b;
         2'd3:    o_rd_bit = i_bits.rs1 ^ op_b;
         default: o_rd_bit = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry    <= 1'b0;
         mismatch <= 1'b0;
      end else if (i_step.en) begin
         carry <= (i_bits.rs1 & b_eff) | (cin & (i_bits.rs1 ^ b_eff));
         // Any differing bit of rs1 and rs2 during EXEC
         if (i_step.phase == bitcore_pkg::PH_EXEC) begin
            mismatch <= (i_bits.rs1 ^ i_bits.rs2) | (mismatch & !i_step.first);
         end
      end
   end

   assign o_eq = !mismatch;

endmodule

// ==== verilog/bitcore_control.sv ====
`include "bitcore_settings.svh"

module bitcore_control (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  bitcore_pkg::instr_u    i_ibus_rdt,
   input  logic                   i_fetched,
   input  logic                   i_mem_done,
   input  logic                   i_eq,
   output bitcore_pkg::step_t     o_step,
   output bitcore_pkg::alu_ctrl_t o_alu,
   output bitcore_pkg::imm_type_e o_imm_type,
   output bitcore_pkg::rd_src_e   o_rd_src,
   output logic                   o_rd_wen,
   output logic [4:0]             o_rd_addr,
   output logic [4:0]             o_rs1_addr,
   output logic [4:0]             o_rs2_addr,
   output logic                   o_store,
   output logic                   o_jump
);

   localparam int CNT_W = $clog2(`BITCORE_XLEN);

   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   bitcore_pkg::phase_e    phase;
   logic [CNT_W-1:0]       cnt;
   logic                   pass_en;
   logic                   pass_last;
   bitcore_pkg::alu_ctrl_t d_alu;
   bitcore_pkg::imm_type_e d_imm;
   bitcore_pkg::rd_src_e   d_src;
   logic [2:0]             d_funct3;
   logic                   d_wen;
   logic                   d_load;
   logic                   d_store;
   logic                   d_jal;
   logic                   d_beq;
   logic                   d_bne;
   logic                   wen_q;
   logic                   load_q;
   logic                   jal_q;
   logic                   beq_q;
   logic                   bne_q;

   assign pass_en   = (phase == bitcore_pkg::PH_EXEC) || (phase == bitcore_pkg::PH_LOADWB) ||
                      (phase == bitcore_pkg::PH_PCUPD);
   assign pass_last = pass_en && (cnt == CNT_W'(`BITCORE_XLEN - 1));
   assign o_step    = '{en: pass_en, first: pass_en && (cnt == '0), last: pass_last,
                        phase: phase};

   always_comb begin
      d_alu    = '{sub: 1'b0, use_imm: 1'b1, bool_op: 2'd0};
      d_imm    = bitcore_pkg::IMM_I;
      d_src    = bitcore_pkg::RD_ALU;
      d_funct3 = i_ibus_rdt.i.funct3;
      d_wen    = 1'b0;
      d_load   = 1'b0;
      d_store  = 1'b0;
      d_jal    = 1'b0;
      d_beq    = 1'b0;
      d_bne    = 1'b0;
      case (i_ibus_rdt.r.opcode)
         OP_REG, OP_IMM: begin
            if (i_ibus_rdt.r.opcode == OP_REG) begin
               d_alu.use_imm = 1'b0;
               d_alu.sub     = i_ibus_rdt.r.funct7[5];
            end
            d_wen = 1'b1;
            // Shifts and compares are not implemented
            case (d_funct3)
               3'b000:  d_alu.bool_op = 2'd0;
               3'b111:  d_alu.bool_op = 2'd1;
               3'b110:  d_alu.bool_op = 2'd2;
               3'b100:  d_alu.bool_op = 2'd3;
               default: d_wen = 1'b0;
            endcase
         end
         OP_LUI: begin
            d_imm = bitcore_pkg::IMM_U;
            d_src = bitcore_pkg::RD_IMM;
            d_wen = 1'b1;
         end
         OP_LOAD: begin
            d_src  = bitcore_pkg::RD_MEM;
            d_load = 1'b1;
         end
         OP_STORE: begin
            d_imm   = bitcore_pkg::IMM_S;
            d_store = 1'b1;
         end
         OP_BRANCH: begin
            d_imm         = bitcore_pkg::IMM_B;
            d_alu.use_imm = 1'b0;
            d_beq         = (d_funct3 == 3'b000);
            d_bne         = (d_funct3 == 3'b001);
         end
         OP_JAL: begin
            d_imm = bitcore_pkg::IMM_J;
            d_src = bitcore_pkg::RD_PC4;
            d_wen = 1'b1;
            d_jal = 1'b1;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= bitcore_pkg::PH_FETCH;
         cnt   <= '0;
      end else begin
         if (pass_en) begin
            cnt <= cnt + 1'b1;
         end
         case (phase)
            bitcore_pkg::PH_FETCH: begin
               if (i_fetched) phase <= bitcore_pkg::PH_EXEC;
            end
            bitcore_pkg::PH_EXEC: begin
               if (pass_last) begin
                  phase <= (load_q || o_store) ? bitcore_pkg::PH_MEM : bitcore_pkg::PH_PCUPD;
               end
            end
            bitcore_pkg::PH_MEM: begin
               if (i_mem_done) begin
                  phase <= load_q ? bitcore_pkg::PH_LOADWB : bitcore_pkg::PH_PCUPD;
               end
            end
            bitcore_pkg::PH_LOADWB: begin
               if (pass_last) phase <= bitcore_pkg::PH_PCUPD;
            end
            default: begin
               if (pass_last) phase <= bitcore_pkg::PH_FETCH;
            end
         endcase
      end
   end

   // Held for the whole instruction
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_alu      <= '0;
         o_imm_type <= bitcore_pkg::IMM_I;
         o_rd_src   <= bitcore_pkg::RD_ALU;
         o_rd_addr  <= '0;
         o_rs1_addr <= '0;
         o_rs2_addr <= '0;
         o_store    <= 1'b0;
         wen_q      <= 1'b0;
         load_q     <= 1'b0;
         jal_q      <= 1'b0;
         beq_q      <= 1'b0;
         bne_q      <= 1'b0;
      end else if (i_fetched) begin
         o_alu      <= d_alu;
         o_imm_type <= d_imm;
         o_rd_src   <= d_src;
         o_rd_addr  <= i_ibus_rdt.i.rd;
         o_rs1_addr <= i_ibus_rdt.i.rs1;
         o_rs2_addr <= i_ibus_rdt.r.rs2;
         o_store    <= d_store;
         wen_q      <= d_wen;
         load_q     <= d_load;
         jal_q      <= d_jal;
         beq_q      <= d_beq;
         bne_q      <= d_bne;
      end
   end

   assign o_rd_wen = (phase == bitcore_pkg::PH_EXEC && wen_q) ||
                     (phase == bitcore_pkg::PH_LOADWB && load_q);

   // eq has settled once EXEC is over
   assign o_jump = jal_q || (beq_q && i_eq) || (bne_q && !i_eq);

endmodule

// ==== verilog/bitcore_immdec.sv ====
`include "bitcore_settings.svh"

module bitcore_immdec (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  bitcore_pkg::instr_u    i_ibus_rdt,
   input  logic                   i_fetched,
   input  bitcore_pkg::imm_type_e i_imm_type,
   input  bitcore_pkg::step_t     i_step,
   output logic                   o_imm_bit
);

   bitcore_pkg::instr_u      ir;
   logic [31:0]              w;
   logic [`BITCORE_XLEN-1:0] imm_full;
   logic [`BITCORE_XLEN-1:0] imm_now;
   logic [`BITCORE_XLEN-1:0] imm_sr;

   assign w = ir;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ir <= '0;
      end else if (i_fetched) begin
         ir <= i_ibus_rdt;
      end
   end

   always_comb begin
      case (i_imm_type)
         bitcore_pkg::IMM_S: imm_full = {{20{w[31]}}, w[31:25], w[11:7]};
         bitcore_pkg::IMM_B: imm_full = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         bitcore_pkg::IMM_U: imm_full = {w[31:12], 12'd0};
         bitcore_pkg::IMM_J: imm_full = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default:            imm_full = {{20{ir.i.imm[11]}}, ir.i.imm};
      endcase
   end

   // Fresh copy at the start of every pass, so PCUPD sees it again
   assign imm_now   = i_step.first ? imm_full : imm_sr;
   assign o_imm_bit = imm_now[0];

   always_ff @(posedge clk) begin
      if (i_step.en) begin
         imm_sr <= {imm_now[`BITCORE_XLEN-1], imm_now[`BITCORE_XLEN-1:1]};
      end
   end

endmodule

// ==== verilog/bitcore_lsu.sv ====
`include "bitcore_settings.svh"

module bitcore_lsu (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  bitcore_pkg::step_t       i_step,
   input  logic                     i_store,
   input  bitcore_pkg::serial_t     i_bits,
   input  logic                     i_alu_bit,
   input  logic [`BITCORE_XLEN-1:0] i_dbus_rdt,
   input  logic                     i_dbus_ack,
   output logic                     o_mem_bit,
   output logic                     o_mem_done,
   output logic [`BITCORE_XLEN-1:0] o_dbus_adr,
   output logic [`BITCORE_XLEN-1:0] o_dbus_dat,
   output logic                     o_dbus_we,
   output logic                     o_dbus_cyc
);

   localparam int W = `BITCORE_XLEN;

   logic [W-1:0] adr_buf;
   logic [W-1:0] dat_buf;

   // One access, for as long as control sits in MEM
   assign o_dbus_cyc = (i_step.phase == bitcore_pkg::PH_MEM);
   assign o_dbus_we  = o_dbus_cyc && i_store;
   assign o_mem_done = o_dbus_cyc && i_dbus_ack;
   assign o_dbus_adr = adr_buf;
   assign o_dbus_dat = dat_buf;
   assign o_mem_bit  = dat_buf[0];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         adr_buf <= '0;
         dat_buf <= '0;
      end else if (i_step.en && i_step.phase == bitcore_pkg::PH_EXEC) begin
         // rs1 + offset from the ALU, rs2 as store data
         adr_buf <= {i_alu_bit, adr_buf[W-1:1]};
         dat_buf <= {i_bits.rs2, dat_buf[W-1:1]};
      end else if (o_mem_done && !i_store) begin
         dat_buf <= i_dbus_rdt;
      end else if (i_step.en && i_step.phase == bitcore_pkg::PH_LOADWB) begin
         dat_buf <= dat_buf >> 1;
      end
   end

endmodule

// ==== verilog/bitcore_pc.sv ====
`include "bitcore_settings.svh"

module bitcore_pc (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  bitcore_pkg::step_t       i_step,
   input  logic                     i_jump,
   input  logic                     i_imm_bit,
   input  logic                     i_ibus_ack,
   output logic                     o_pc4_bit,
   output logic                     o_fetched,
   output logic [`BITCORE_XLEN-1:0] o_ibus_adr,
   output logic                     o_ibus_cyc
);

   logic [`BITCORE_XLEN-1:0] pc;
   logic [1:0]               four_sr;
   logic                     four_bit;
   logic                     in_exec;
   logic                     in_pcupd;
   logic                     addend;
   logic                     cin;
   logic                     carry;
   logic                     sum;

   assign in_exec  = i_step.en && (i_step.phase == bitcore_pkg::PH_EXEC);
   assign in_pcupd = i_step.en && (i_step.phase == bitcore_pkg::PH_PCUPD);

   // Constant 4 as a bit stream, only bit 2 set
   assign four_bit = !i_step.first && four_sr[0];
   assign addend   = (in_pcupd && i_jump) ? i_imm_bit : four_bit;
   assign cin      = !i_step.first && carry;
   assign sum      = pc[0] ^ addend ^ cin;

   assign o_pc4_bit  = sum;
   assign o_fetched  = o_ibus_cyc && i_ibus_ack;
   assign o_ibus_adr = pc;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc         <= `BITCORE_RESET_PC;
         four_sr    <= '0;
         carry      <= 1'b0;
         o_ibus_cyc <= 1'b1;
      end else begin
         if (i_step.en) begin
            four_sr <= i_step.first ? 2'b10 : four_sr >> 1;
            carry   <= (pc[0] & addend) | (cin & (pc[0] ^ addend));
         end
         // EXEC turns the PC fully around unchanged, PCUPD shifts in the sum
         if (in_exec) begin
            pc <= {pc[0], pc[`BITCORE_XLEN-1:1]};
         end else if (in_pcupd) begin
            pc <= {sum, pc[`BITCORE_XLEN-1:1]};
         end
         if (o_fetched) begin
            o_ibus_cyc <= 1'b0;
         end else if (in_pcupd && i_step.last) begin
            o_ibus_cyc <= 1'b1;
         end
      end
   end

endmodule

// ==== verilog/bitcore_pkg.sv ====
package bitcore_pkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fields_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fields_t;

   // One fetched word, read as R-type or I-type
   typedef union packed {
      r_fields_t r;
      i_fields_t i;
   } instr_u;

   typedef enum logic [2:0] {
      PH_FETCH, PH_EXEC, PH_MEM, PH_LOADWB, PH_PCUPD
   } phase_e;

   // bool_op: 0 add/sub, 1 and, 2 or, 3 xor
   typedef struct packed {
      logic       sub;
      logic       use_imm;
      logic [1:0] bool_op;
   } alu_ctrl_t;

   typedef enum logic [1:0] {
      RD_ALU, RD_IMM, RD_PC4, RD_MEM
   } rd_src_e;

   typedef enum logic [2:0] {
      IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
   } imm_type_e;

   typedef struct packed {
      logic   en;
      logic   first;
      logic   last;
      phase_e phase;
   } step_t;

   typedef struct packed {
      logic rs1;
      logic rs2;
      logic imm;
   } serial_t;

endpackage

// ==== verilog/bitcore_regfile.sv ====
`include "bitcore_settings.svh"

module bitcore_regfile (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  bitcore_pkg::step_t   i_step,
   input  logic [4:0]           i_rs1_addr,
   input  logic [4:0]           i_rs2_addr,
   input  logic [4:0]           i_rd_addr,
   input  logic                 i_rd_wen,
   input  bitcore_pkg::rd_src_e i_rd_src,
   input  logic                 i_alu_bit,
   input  logic                 i_imm_bit,
   input  logic                 i_pc4_bit,
   input  logic                 i_mem_bit,
   output logic [1:0]           o_rs
);

   localparam int W = `BITCORE_XLEN;

   logic [W-1:0] regs [1:31];
   logic [W-1:0] rs1_rd;
   logic [W-1:0] rs2_rd;
   logic [W-1:0] rs1_now;
   logic [W-1:0] rs2_now;
   logic [W-1:0] rs1_sr;
   logic [W-1:0] rs2_sr;
   logic         load;
   logic         rd_bit;

   // x0 has no storage
   assign rs1_rd = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
   assign rs2_rd = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

   assign load    = i_step.first && (i_step.phase == bitcore_pkg::PH_EXEC);
   assign rs1_now = load ? rs1_rd : rs1_sr;
   assign rs2_now = load ? rs2_rd : rs2_sr;
   assign o_rs    = {rs1_now[0], rs2_now[0]};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rs1_sr <= '0;
         rs2_sr <= '0;
      end else if (i_step.en && i_step.phase == bitcore_pkg::PH_EXEC) begin
         rs1_sr <= rs1_now >> 1;
         rs2_sr <= rs2_now >> 1;
      end
   end

   always_comb begin
      case (i_rd_src)
         bitcore_pkg::RD_IMM: rd_bit = i_imm_bit;
         bitcore_pkg::RD_PC4: rd_bit = i_pc4_bit;
         bitcore_pkg::RD_MEM: rd_bit = i_mem_bit;
         default:             rd_bit = i_alu_bit;
      endcase
   end

   // Result enters at the top, after 32 bits it is in place
   always_ff @(posedge clk) begin
      if (i_step.en && i_rd_wen && i_rd_addr != 5'd0) begin
         regs[i_rd_addr] <= {rd_bit, regs[i_rd_addr][W-1:1]};
      end
   end

endmodule

// ==== verilog/bitcore_settings.svh ====
`ifndef BITCORE_SETTINGS_SVH
`define BITCORE_SETTINGS_SVH

// First fetch address out of reset
`define BITCORE_RESET_PC 32'h0000_0000

// Word width, also the length of one serial pass
`define BITCORE_XLEN 32

`endif

// ==== verilog/bitcore_top.sv ====
`include "bitcore_settings.svh"

module bitcore_top (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic [`BITCORE_XLEN-1:0] i_ibus_rdt,
   input  logic                     i_ibus_ack,
   input  logic [`BITCORE_XLEN-1:0] i_dbus_rdt,
   input  logic                     i_dbus_ack,
   output logic [`BITCORE_XLEN-1:0] o_ibus_adr,
   output logic                     o_ibus_cyc,
   output logic [`BITCORE_XLEN-1:0] o_dbus_adr,
   output logic [`BITCORE_XLEN-1:0] o_dbus_dat,
   output logic                     o_dbus_we,
   output logic                     o_dbus_cyc
);

   bitcore_pkg::step_t     step;
   bitcore_pkg::alu_ctrl_t alu_ctrl;
   bitcore_pkg::imm_type_e imm_type;
   bitcore_pkg::rd_src_e   rd_src;
   bitcore_pkg::serial_t   bits;
   logic                   rd_wen;
   logic [4:0]             rd_addr;
   logic [4:0]             rs1_addr;
   logic [4:0]             rs2_addr;
   logic                   store;
   logic                   jump;
   logic                   fetched;
   logic                   mem_done;
   logic                   eq;
   logic [1:0]             rs;
   logic                   imm_bit;
   logic                   alu_bit;
   logic                   pc4_bit;
   logic                   mem_bit;

   assign bits = '{rs1: rs[1], rs2: rs[0], imm: imm_bit};

   bitcore_control u_control (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_fetched  (fetched),
      .i_mem_done (mem_done),
      .i_eq       (eq),
      .o_step     (step),
      .o_alu      (alu_ctrl),
      .o_imm_type (imm_type),
      .o_rd_src   (rd_src),
      .o_rd_wen   (rd_wen),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_store    (store),
      .o_jump     (jump)
   );

   bitcore_immdec u_immdec (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_fetched  (fetched),
      .i_imm_type (imm_type),
      .i_step     (step),
      .o_imm_bit  (imm_bit)
   );

   bitcore_alu u_alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_step   (step),
      .i_alu    (alu_ctrl),
      .i_bits   (bits),
      .o_rd_bit (alu_bit),
      .o_eq     (eq)
   );

   bitcore_regfile u_regfile (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_step     (step),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_wen   (rd_wen),
      .i_rd_src   (rd_src),
      .i_alu_bit  (alu_bit),
      .i_imm_bit  (imm_bit),
      .i_pc4_bit  (pc4_bit),
      .i_mem_bit  (mem_bit),
      .o_rs       (rs)
   );

   bitcore_pc u_pc (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_step     (step),
      .i_jump     (jump),
      .i_imm_bit  (imm_bit),
      .i_ibus_ack (i_ibus_ack),
      .o_pc4_bit  (pc4_bit),
      .o_fetched  (fetched),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc)
   );

   bitcore_lsu u_lsu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_step     (step),
      .i_store    (store),
      .i_bits     (bits),
      .i_alu_bit  (alu_bit),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_mem_bit  (mem_bit),
      .o_mem_done (mem_done),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc)
   );

endmodule
